// ==== fpga_core_cfg.svh ====
// Build-time defaults for the board core, included by the RTL and the testbench.
`ifndef FPGA_CORE_CFG_SVH
`define FPGA_CORE_CFG_SVH

// Clock cycles per UART bit.
// 125 MHz system clock at 115200 baud.
`define FPGA_CORE_BIT_CYCLES 16'd1085

// Entries in the loopback byte queue.
// Must be a power of two.
`define FPGA_CORE_FIFO_DEPTH 16

// Address width of the byte queue.
// The queue pointers carry one extra wrap bit on top of this.
`define FPGA_CORE_FIFO_AW 4

`endif

// ==== fpga_core_pkg.sv ====
// Shared types for the board core: data byte, queue pointer and UART state encodings.
`include "fpga_core_cfg.svh"

package fpga_core_pkg;

    // One serial data byte.
    typedef logic [7:0] uart_byte_t;

    // Queue pointer with a wrap bit so full and empty differ.
    typedef logic [`FPGA_CORE_FIFO_AW:0] fifo_ptr_t;

    // Receiver FSM.
    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } rx_state_t;

    // Transmitter FSM.
    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } tx_state_t;

endpackage

// ==== uart_rx.sv ====
// 8N1 serial receiver; strobes each decoded byte and flags frames with a bad stop bit.
`timescale 1ns/1ps
`include "fpga_core_cfg.svh"

module uart_rx #(
    parameter int BIT_CYCLES = `FPGA_CORE_BIT_CYCLES
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rxd,
    output fpga_core_pkg::uart_byte_t rx_data,
    output logic                      rx_valid,
    output logic                      busy,
    output logic                      frame_error
);

    localparam logic [15:0] BIT_LOAD  = 16'(BIT_CYCLES - 1);
    localparam logic [15:0] HALF_LOAD = 16'(BIT_CYCLES / 2 - 1);

    logic                      rxd_meta;
    logic                      rxd_sync;
    fpga_core_pkg::rx_state_t  state;
    logic [15:0]               bit_timer;
    logic [2:0]                bit_idx;
    logic                      bit_done;
    fpga_core_pkg::uart_byte_t shift_reg;

    // Two-flop synchronizer, parked high like an idle line.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    assign bit_done = (bit_timer == 16'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= fpga_core_pkg::RX_IDLE;
            bit_timer   <= 16'd0;
            bit_idx     <= 3'd0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (state != fpga_core_pkg::RX_IDLE && !bit_done) begin
                bit_timer <= bit_timer - 16'd1;
            end
            case (state)
                fpga_core_pkg::RX_IDLE: begin
                    // Start edge seen, aim for the middle of the start bit.
                    if (!rxd_sync) begin
                        state     <= fpga_core_pkg::RX_START;
                        bit_timer <= HALF_LOAD;
                    end
                end
                fpga_core_pkg::RX_START: begin
                    if (bit_done) begin
                        if (rxd_sync) begin
                            // Line went back high, treat it as a glitch.
                            state <= fpga_core_pkg::RX_IDLE;
                        end else begin
                            state     <= fpga_core_pkg::RX_DATA;
                            bit_timer <= BIT_LOAD;
                            bit_idx   <= 3'd0;
                        end
                    end
                end
                fpga_core_pkg::RX_DATA: begin
                    if (bit_done) begin
                        bit_timer <= BIT_LOAD;
                        if (bit_idx == 3'd7) begin
                            state <= fpga_core_pkg::RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                fpga_core_pkg::RX_STOP: begin
                    if (bit_done) begin
                        state <= fpga_core_pkg::RX_IDLE;
                        if (rxd_sync) begin
                            rx_valid <= 1'b1;
                        end else begin
                            frame_error <= 1'b1;
                        end
                    end
                end
                default: state <= fpga_core_pkg::RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first.
    always_ff @(posedge clk) begin
        if (state == fpga_core_pkg::RX_DATA && bit_done) begin
            shift_reg <= {rxd_sync, shift_reg[7:1]};
        end
    end

    assign rx_data = shift_reg;
    assign busy    = (state != fpga_core_pkg::RX_IDLE);

    // A frame ends either good or bad, never both.
    assert property (@(posedge clk) disable iff (!rst_n)
        !(rx_valid && $rose(frame_error)));

endmodule

// ==== byte_fifo.sv ====
// Circular byte queue between receiver and transmitter; hands one byte at a time to an idle TX.
`timescale 1ns/1ps
`include "fpga_core_cfg.svh"

module byte_fifo #(
    // Must not exceed the configured queue address width.
    parameter int DEPTH_LOG2 = `FPGA_CORE_FIFO_AW
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fpga_core_pkg::uart_byte_t wr_data,
    input  logic                      wr_valid,
    input  logic                      tx_busy,
    output fpga_core_pkg::uart_byte_t tx_data,
    output logic                      tx_valid
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    fpga_core_pkg::uart_byte_t mem [DEPTH];
    fpga_core_pkg::fifo_ptr_t  wr_ptr;
    fpga_core_pkg::fifo_ptr_t  rd_ptr;
    logic                      empty;
    logic                      full;
    logic                      release_byte;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (fpga_core_pkg::fifo_ptr_t'(wr_ptr - rd_ptr)
                    == fpga_core_pkg::fifo_ptr_t'(DEPTH));

    // The previous strobe blocks a second one before tx_busy rises.
    assign release_byte = !empty && !tx_busy && !tx_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            tx_valid <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= wr_ptr + fpga_core_pkg::fifo_ptr_t'(1);
            end
            if (release_byte) begin
                rd_ptr <= rd_ptr + fpga_core_pkg::fifo_ptr_t'(1);
            end
            tx_valid <= release_byte;
        end
    end

    // Storage and the outgoing byte.
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= wr_data;
        end
        if (release_byte) begin
            tx_data <= mem[rd_ptr[DEPTH_LOG2-1:0]];
        end
    end

    // No back-pressure toward the receiver, so a full queue must never be written.
    assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_valid && full));

    // The transmitter accepts each strobe and reports busy in the next cycle.
    assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid |=> tx_busy);

endmodule

// ==== uart_tx.sv ====
// 8N1 serial transmitter; sends one byte per input strobe and reports busy for the frame.
`timescale 1ns/1ps
`include "fpga_core_cfg.svh"

module uart_tx #(
    parameter int BIT_CYCLES = `FPGA_CORE_BIT_CYCLES
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fpga_core_pkg::uart_byte_t tx_data,
    input  logic                      tx_valid,
    output logic                      txd,
    output logic                      busy
);

    localparam logic [15:0] BIT_LOAD = 16'(BIT_CYCLES - 1);

    fpga_core_pkg::tx_state_t  state;
    logic [15:0]               bit_timer;
    logic [2:0]                bit_idx;
    logic                      bit_done;
    fpga_core_pkg::uart_byte_t shift_reg;

    assign bit_done = (bit_timer == 16'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= fpga_core_pkg::TX_IDLE;
            bit_timer <= 16'd0;
            bit_idx   <= 3'd0;
            txd       <= 1'b1;
            busy      <= 1'b0;
        end else begin
            if (state != fpga_core_pkg::TX_IDLE && !bit_done) begin
                bit_timer <= bit_timer - 16'd1;
            end
            case (state)
                fpga_core_pkg::TX_IDLE: begin
                    if (tx_valid) begin
                        state     <= fpga_core_pkg::TX_START;
                        bit_timer <= BIT_LOAD;
                        txd       <= 1'b0;
                        busy      <= 1'b1;
                    end
                end
                fpga_core_pkg::TX_START: begin
                    if (bit_done) begin
                        state     <= fpga_core_pkg::TX_DATA;
                        bit_timer <= BIT_LOAD;
                        bit_idx   <= 3'd0;
                        txd       <= shift_reg[0];
                    end
                end
                fpga_core_pkg::TX_DATA: begin
                    if (bit_done) begin
                        bit_timer <= BIT_LOAD;
                        if (bit_idx == 3'd7) begin
                            state <= fpga_core_pkg::TX_STOP;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            txd     <= shift_reg[1];
                        end
                    end
                end
                fpga_core_pkg::TX_STOP: begin
                    // Busy drops as the stop bit ends.
                    if (bit_done) begin
                        state <= fpga_core_pkg::TX_IDLE;
                        busy  <= 1'b0;
                    end
                end
                default: state <= fpga_core_pkg::TX_IDLE;
            endcase
        end
    end

    // Load on the strobe, then shift right as each data bit ends.
    always_ff @(posedge clk) begin
        if (state == fpga_core_pkg::TX_IDLE && tx_valid) begin
            shift_reg <= tx_data;
        end else if (state == fpga_core_pkg::TX_DATA && bit_done) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    // The queue only offers a byte to an idle transmitter.
    assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid |-> !busy);

endmodule

// ==== fpga_core.sv ====
// Board core logic: switches and buttons to LEDs, plus a UART byte loopback through a queue.
`timescale 1ns/1ps
`include "fpga_core_cfg.svh"

module fpga_core #(
    parameter int BIT_CYCLES = `FPGA_CORE_BIT_CYCLES
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] btn,
    input  logic [3:0] sw,
    input  logic       uart_rxd,
    output logic       uart_txd,
    output logic       led0_r,
    output logic       led0_g,
    output logic       led0_b,
    output logic       led1_r,
    output logic       led1_g,
    output logic       led1_b,
    output logic       led2_r,
    output logic       led2_g,
    output logic       led2_b,
    output logic       led3_r,
    output logic       led3_g,
    output logic       led3_b,
    output logic       led4,
    output logic       led5,
    output logic       led6,
    output logic       led7
);

    fpga_core_pkg::uart_byte_t rx_data;
    fpga_core_pkg::uart_byte_t tx_data;
    logic                      rx_valid;
    logic                      rx_busy;
    logic                      rx_frame_error;
    logic                      tx_valid;
    logic                      tx_busy;

    // Queue depth and address width come from the same header.
    if ((1 << `FPGA_CORE_FIFO_AW) != `FPGA_CORE_FIFO_DEPTH) begin : g_depth_check
        $error("Queue depth does not match its address width.");
    end

    // GPIO straight to the LEDs.
    assign {led7, led6, led5, led4} = sw;
    assign {led3_g, led2_g, led1_g, led0_g} = btn;

    // Red LEDs show UART status; blue is unused.
    assign led0_r = rx_busy;
    assign led1_r = tx_busy;
    assign led2_r = rx_frame_error;
    assign led3_r = 1'b0;
    assign {led3_b, led2_b, led1_b, led0_b} = 4'b0000;

    uart_rx #(.BIT_CYCLES(BIT_CYCLES)) uart_rx_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxd         (uart_rxd),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .busy        (rx_busy),
        .frame_error (rx_frame_error)
    );

    byte_fifo #(.DEPTH_LOG2(`FPGA_CORE_FIFO_AW)) byte_fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_data  (rx_data),
        .wr_valid (rx_valid),
        .tx_busy  (tx_busy),
        .tx_data  (tx_data),
        .tx_valid (tx_valid)
    );

    uart_tx #(.BIT_CYCLES(BIT_CYCLES)) uart_tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .txd      (uart_txd),
        .busy     (tx_busy)
    );

endmodule

// ==== tb_fpga_core.sv ====
// Self-checking testbench for the board core; drives GPIO and UART frames and checks LEDs and echo.
`timescale 1ns/1ps
`include "fpga_core_cfg.svh"

module tb_fpga_core;

    localparam int BIT_CYCLES      = 16;
    localparam int N_GOOD          = 40;
    localparam int N_AFTER_ERR     = 5;
    localparam int N_FRAMES        = N_GOOD + 1 + N_AFTER_ERR;
    localparam int DRAIN_BITS      = 20;
    localparam int WATCHDOG_CYCLES = N_FRAMES * 12 * BIT_CYCLES + 60 * BIT_CYCLES + 1000;

    logic       clk;
    logic       rst_n;
    logic [3:0] btn;
    logic [3:0] sw;
    logic       uart_rxd;
    logic       uart_txd;
    logic       led0_r, led0_g, led0_b;
    logic       led1_r, led1_g, led1_b;
    logic       led2_r, led2_g, led2_b;
    logic       led3_r, led3_g, led3_b;
    logic       led4, led5, led6, led7;

    int seed      = 53;
    int sent_good = 0;
    int echoed    = 0;

    // Bytes still expected back on uart_txd, oldest first.
    fpga_core_pkg::uart_byte_t model_q[$];

    fpga_core #(.BIT_CYCLES(BIT_CYCLES)) dut_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            abort_run();
        end
    endtask

    // One 8N1 frame on uart_rxd followed by gap_bits of idle line.
    task automatic send_frame(input fpga_core_pkg::uart_byte_t data, input logic stop_bit,
                              input int gap_bits);
        logic [9:0] frame;
        int         i;
        frame = {stop_bit, data, 1'b0};
        if (stop_bit) begin
            model_q.push_back(data);
            sent_good++;
        end
        assert (model_q.size() <= `FPGA_CORE_FIFO_DEPTH + 2) else begin
            $display("ERROR: more bytes in flight than the loopback queue can hold");
            abort_run();
        end
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rxd <= frame[i];
            // The receiver is busy for the whole frame.
            if (i == 4) begin
                check_value("led0_r", 1, led0_r);
            end
            repeat (BIT_CYCLES - 1) @(posedge clk);
        end
        // A bad stop bit is followed by one bit of idle so the next start edge is clean.
        if (!stop_bit) begin
            @(posedge clk);
            uart_rxd <= 1'b1;
            repeat (BIT_CYCLES - 1) @(posedge clk);
        end
        repeat (gap_bits * BIT_CYCLES) @(posedge clk);
    endtask

    // Serial monitor that samples each echoed bit near its middle.
    initial begin : monitor
        fpga_core_pkg::uart_byte_t got;
        fpga_core_pkg::uart_byte_t expected;
        int                        i;
        forever begin
            @(negedge uart_txd);
            repeat (BIT_CYCLES / 2) @(negedge clk);
            check_value("uart_txd start bit", 0, uart_txd);
            check_value("led1_r", 1, led1_r);
            for (i = 0; i < 8; i++) begin
                repeat (BIT_CYCLES) @(negedge clk);
                got[i] = uart_txd;
            end
            repeat (BIT_CYCLES) @(negedge clk);
            check_value("uart_txd stop bit", 1, uart_txd);
            assert (model_q.size() > 0) else begin
                $display("ERROR: a byte was echoed on uart_txd when none was expected");
                abort_run();
            end
            expected = model_q.pop_front();
            check_value("uart_txd data", expected, got);
            echoed++;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: simulation did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin : stimulus
        int         n;
        int         gap;
        logic [3:0] sw_val;
        logic [3:0] btn_val;
        rst_n    = 1'b0;
        uart_rxd = 1'b1;
        sw       = 4'h0;
        btn      = 4'h0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(negedge clk);

        // Idle state after reset.
        check_value("uart_txd", 1, uart_txd);
        check_value("led0_r", 0, led0_r);
        check_value("led1_r", 0, led1_r);
        check_value("led2_r", 0, led2_r);

        // Switches and buttons go straight to the LEDs.
        for (n = 0; n < 20; n++) begin
            sw_val  = 4'($random(seed));
            btn_val = 4'($random(seed));
            @(posedge clk);
            sw  <= sw_val;
            btn <= btn_val;
            @(posedge clk);
            @(negedge clk);
            check_value("led7..led4", sw_val, {led7, led6, led5, led4});
            check_value("led3_g..led0_g", btn_val, {led3_g, led2_g, led1_g, led0_g});
            check_value("blue leds and led3_r", 0, {led3_b, led2_b, led1_b, led0_b, led3_r});
        end

        // Loopback with the first frames back to back.
        for (n = 0; n < N_GOOD; n++) begin
            gap = (n < 4) ? 0 : ($random(seed) & 3);
            send_frame(8'($random(seed)), 1'b1, gap);
        end

        // Framing error lights led2_r and echoes nothing.
        check_value("led2_r", 0, led2_r);
        send_frame(8'($random(seed)), 1'b0, 2);
        check_value("led2_r", 1, led2_r);
        for (n = 0; n < N_AFTER_ERR; n++) begin
            send_frame(8'($random(seed)), 1'b1, $random(seed) & 3);
        end

        // Once drained the line must stay idle.
        while (model_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (BIT_CYCLES) @(negedge clk);
        for (n = 0; n < DRAIN_BITS * BIT_CYCLES; n++) begin
            @(negedge clk);
            check_value("uart_txd", 1, uart_txd);
            check_value("led1_r", 0, led1_r);
            check_value("led2_r", 1, led2_r);
        end
        check_value("echoed byte count", sent_good, echoed);

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== fpga_core.f ====
+incdir+.
fpga_core_pkg.sv
uart_rx.sv
byte_fifo.sv
uart_tx.sv
fpga_core.sv
tb_fpga_core.sv

// ==== Makefile ====
# Verilator lint, simulation and clean targets for the board core.

VERILATOR ?= verilator
TOP       ?= tb_fpga_core
RTL_TOP   ?= fpga_core
FILELIST  ?= fpga_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
RTL_SRCS  ?= fpga_core_pkg.sv uart_rx.sv byte_fifo.sv uart_tx.sv fpga_core.sv
FAIL_MSG  := ** FAIL **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+. $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) tb_fpga_core.sv fpga_core_cfg.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
